// ==== Makefile ====
# Verilator build and run for the execute stage testbench

LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal --top-module tb_exe_stage \
		-f sources.f -o Vtb_exe_stage

run: compile
	./obj_dir/Vtb_exe_stage | tee $(LOG)
	grep -q '^test passed$$' $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== sources.f ====
src/exe_pkg.sv
src/exe_if.sv
src/exe_ctrl.sv
src/alu_unit.sv
src/trap_unit.sv
src/csr_file.sv
src/instret_counter.sv
src/exe_stage_top.sv
tb/tb_exe_stage.sv

// ==== src/alu_unit.sv ====
// results update only on i_fire and hold until the next fire
// csr write is a single-cycle strobe during i_fire
`default_nettype none

module alu_unit (
  input  wire                        clk,
  input  wire                        rst,
  issue_if.dst                       issue,
  input  wire                        i_fire,
  csr_if.master                      csr,
  output logic [exe_pkg::xlen-1:0]   o_rd_wdata,
  output logic                       o_pc_jmp,
  output logic [exe_pkg::xlen-1:0]   o_pc_jmpaddr
);

  logic [exe_pkg::xlen-1:0] result;
  logic [exe_pkg::xlen-1:0] target;
  logic [5:0]               shamt;
  logic                     take_jmp;
  logic                     csr_write;

  assign shamt  = issue.op2[5:0];
  assign target = issue.pc + issue.op3;

  assign csr.addr  = issue.op3[exe_pkg::csr_addr_w-1:0];
  // csrrs with a zero mask is a pure read
  assign csr_write = (issue.op == exe_pkg::OP_CSRRW) ||
                     ((issue.op == exe_pkg::OP_CSRRS) && (issue.op1 != '0));
  assign csr.wen   = i_fire & csr_write;
  assign csr.wdata = (issue.op == exe_pkg::OP_CSRRW) ? issue.op1 : (csr.rdata | issue.op1);

  always_comb begin
    take_jmp = 1'b0;
    case (issue.op)
      exe_pkg::OP_ADD:   result = issue.op1 + issue.op2;
      exe_pkg::OP_SUB:   result = issue.op1 - issue.op2;
      exe_pkg::OP_AND:   result = issue.op1 & issue.op2;
      exe_pkg::OP_OR:    result = issue.op1 | issue.op2;
      exe_pkg::OP_XOR:   result = issue.op1 ^ issue.op2;
      exe_pkg::OP_SLL:   result = issue.op1 << shamt;
      exe_pkg::OP_SRL:   result = issue.op1 >> shamt;
      exe_pkg::OP_SLT:   result = {63'd0, $signed(issue.op1) < $signed(issue.op2)};
      exe_pkg::OP_BEQ: begin
        result   = '0;
        take_jmp = (issue.op1 == issue.op2);
      end
      exe_pkg::OP_JAL: begin
        result   = issue.pc + 64'd4;
        take_jmp = 1'b1;
      end
      exe_pkg::OP_CSRRW: result = csr.rdata;
      exe_pkg::OP_CSRRS: result = csr.rdata;
      default:           result = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      o_pc_jmp <= 1'b0;
    end else if (i_fire) begin
      o_pc_jmp <= take_jmp;
    end
  end

  always_ff @(posedge clk) begin
    if (i_fire) begin
      o_rd_wdata   <= result;
      o_pc_jmpaddr <= target;
    end
  end

endmodule

`default_nettype wire

// ==== src/csr_file.sv ====
// unknown addresses read zero and drop writes
// minstret is read-only and mirrors the retire counter
`default_nettype none

module csr_file (
  input  wire                        clk,
  input  wire                        rst,
  csr_if.slave                       csr,
  input  wire                        i_trap_we,
  input  wire  [exe_pkg::xlen-1:0]   i_trap_epc,
  input  wire  [exe_pkg::xlen-1:0]   i_trap_cause,
  input  wire  [exe_pkg::xlen-1:0]   i_instret,
  output logic [exe_pkg::xlen-1:0]   o_mtvec,
  output logic [exe_pkg::xlen-1:0]   o_mepc
);

  logic [exe_pkg::xlen-1:0] mcause;
  logic [exe_pkg::xlen-1:0] mscratch;

  always_ff @(posedge clk) begin
    if (rst) begin
      o_mtvec  <= '0;
      o_mepc   <= '0;
      mcause   <= '0;
      mscratch <= '0;
    end else if (i_trap_we) begin
      // trap write wins
      o_mepc <= i_trap_epc;
      mcause <= i_trap_cause;
    end else if (csr.wen) begin
      case (csr.addr)
        exe_pkg::csr_mtvec:    o_mtvec  <= csr.wdata;
        exe_pkg::csr_mepc:     o_mepc   <= csr.wdata;
        exe_pkg::csr_mcause:   mcause   <= csr.wdata;
        exe_pkg::csr_mscratch: mscratch <= csr.wdata;
        default: ;
      endcase
    end
  end

  always_comb begin
    case (csr.addr)
      exe_pkg::csr_mtvec:    csr.rdata = o_mtvec;
      exe_pkg::csr_mepc:     csr.rdata = o_mepc;
      exe_pkg::csr_mcause:   csr.rdata = mcause;
      exe_pkg::csr_mscratch: csr.rdata = mscratch;
      exe_pkg::csr_minstret: csr.rdata = i_instret;
      default:               csr.rdata = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== src/exe_ctrl.sv ====
// one instruction in flight; decode ack only while idle
// alu result ready 2 cycles after accept, trap 3 cycles after
`default_nettype none

module exe_ctrl (
  input  wire                              clk,
  input  wire                              rst,
  input  wire                              i_dec_req,
  output logic                             o_dec_ack,
  input  exe_pkg::exe_op_t                 i_op,
  input  wire  [exe_pkg::xlen-1:0]         i_pc,
  input  wire  [exe_pkg::xlen-1:0]         i_op1,
  input  wire  [exe_pkg::xlen-1:0]         i_op2,
  input  wire  [exe_pkg::xlen-1:0]         i_op3,
  input  wire  [exe_pkg::ridx_w-1:0]       i_rd,
  input  wire                              i_rd_wen,
  issue_if.src                             issue,
  output logic                             o_alu_fire,
  output logic                             o_trap_start,
  input  wire                              i_trap_done,
  output logic                             o_sel_trap,
  output logic                             o_exe_req,
  input  wire                              i_exe_ack,
  output logic                             o_retire
);

  exe_pkg::ctrl_state_t state;
  logic launched;
  logic unit_done;
  logic accept;
  logic is_trap_op;

  assign o_dec_ack  = (state == exe_pkg::ST_IDLE);
  assign o_exe_req  = (state == exe_pkg::ST_HOLD);
  assign o_retire   = o_exe_req & i_exe_ack;
  assign accept     = i_dec_req & o_dec_ack;
  assign is_trap_op = (i_op == exe_pkg::OP_ECALL) || (i_op == exe_pkg::OP_MRET);
  // alu finishes in its fire cycle, trap unit reports on its own
  assign unit_done  = (state == exe_pkg::ST_ALU) ? o_alu_fire : i_trap_done;

  always_ff @(posedge clk) begin
    if (rst) begin
      state        <= exe_pkg::ST_IDLE;
      launched     <= 1'b0;
      o_alu_fire   <= 1'b0;
      o_trap_start <= 1'b0;
      o_sel_trap   <= 1'b0;
    end else begin
      o_alu_fire   <= 1'b0;
      o_trap_start <= 1'b0;
      case (state)
        exe_pkg::ST_IDLE: begin
          if (accept) begin
            state      <= is_trap_op ? exe_pkg::ST_TRAP : exe_pkg::ST_ALU;
            o_sel_trap <= is_trap_op;
          end
        end
        exe_pkg::ST_ALU, exe_pkg::ST_TRAP: begin
          if (!launched) begin
            launched <= 1'b1;
            if (state == exe_pkg::ST_ALU) begin
              o_alu_fire <= 1'b1;
            end else begin
              o_trap_start <= 1'b1;
            end
          end else if (unit_done) begin
            launched <= 1'b0;
            state    <= exe_pkg::ST_HOLD;
          end
        end
        exe_pkg::ST_HOLD: begin
          if (i_exe_ack) begin
            state <= exe_pkg::ST_IDLE;
          end
        end
        default: state <= exe_pkg::ST_IDLE;
      endcase
    end
  end

  // bundle stays put until the next accept
  always_ff @(posedge clk) begin
    if (accept) begin
      issue.op  <= i_op;
      issue.pc  <= i_pc;
      issue.op1 <= i_op1;
      issue.op2 <= i_op2;
      issue.op3 <= i_op3;
      issue.rd  <= i_rd;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      issue.rd_wen <= 1'b0;
    end else if (accept) begin
      issue.rd_wen <= i_rd_wen;
    end
  end

endmodule

`default_nettype wire

// ==== src/exe_if.sv ====
// issued instruction bundle and single CSR access port
`default_nettype none

interface issue_if;
  exe_pkg::exe_op_t              op;
  logic [exe_pkg::xlen-1:0]      pc;
  logic [exe_pkg::xlen-1:0]      op1;
  logic [exe_pkg::xlen-1:0]      op2;
  logic [exe_pkg::xlen-1:0]      op3;
  logic [exe_pkg::ridx_w-1:0]    rd;
  logic                          rd_wen;

  modport src (output op, pc, op1, op2, op3, rd, rd_wen);
  modport dst (input op, pc, op1, op2, op3, rd, rd_wen);
endinterface

interface csr_if;
  logic [exe_pkg::csr_addr_w-1:0] addr;
  logic                           wen;
  logic [exe_pkg::xlen-1:0]       wdata;
  logic [exe_pkg::xlen-1:0]       rdata;

  modport master (output addr, wen, wdata, input rdata);
  modport slave (input addr, wen, wdata, output rdata);
endinterface

`default_nettype wire

// ==== src/exe_pkg.sv ====
// shared types and constants for the execute stage
// opcode encoding is local to this stage, not the RISC-V instruction encoding
`default_nettype none

package exe_pkg;

  localparam int xlen       = 64;
  localparam int ridx_w     = 5;
  localparam int csr_addr_w = 12;

  // machine CSR addresses
  localparam logic [csr_addr_w-1:0] csr_mtvec    = 12'h305;
  localparam logic [csr_addr_w-1:0] csr_mscratch = 12'h340;
  localparam logic [csr_addr_w-1:0] csr_mepc     = 12'h341;
  localparam logic [csr_addr_w-1:0] csr_mcause   = 12'h342;
  localparam logic [csr_addr_w-1:0] csr_minstret = 12'hB02;

  // environment call from M-mode
  localparam logic [xlen-1:0] cause_ecall_m = 64'd11;

  typedef enum logic [3:0] {
    OP_ADD,
    OP_SUB,
    OP_AND,
    OP_OR,
    OP_XOR,
    OP_SLL,
    OP_SRL,
    OP_SLT,
    OP_BEQ,
    OP_JAL,
    OP_CSRRW,
    OP_CSRRS,
    OP_ECALL,
    OP_MRET
  } exe_op_t;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ALU,
    ST_TRAP,
    ST_HOLD
  } ctrl_state_t;

endpackage

`default_nettype wire

// ==== src/exe_stage_top.sv ====
// results are valid only while o_exe_req is high
// trap results always jump and never write rd
`default_nettype none

module exe_stage_top (
  input  wire                              clk,
  input  wire                              rst,
  input  wire                              i_dec_req,
  output logic                             o_dec_ack,
  input  exe_pkg::exe_op_t                 i_op,
  input  wire  [exe_pkg::xlen-1:0]         i_pc,
  input  wire  [exe_pkg::xlen-1:0]         i_op1,
  input  wire  [exe_pkg::xlen-1:0]         i_op2,
  input  wire  [exe_pkg::xlen-1:0]         i_op3,
  input  wire  [exe_pkg::ridx_w-1:0]       i_rd,
  input  wire                              i_rd_wen,
  output logic                             o_exe_req,
  input  wire                              i_exe_ack,
  output logic [exe_pkg::xlen-1:0]         o_pc,
  output logic [exe_pkg::ridx_w-1:0]       o_rd,
  output logic                             o_rd_wen,
  output logic [exe_pkg::xlen-1:0]         o_rd_wdata,
  output logic                             o_pc_jmp,
  output logic [exe_pkg::xlen-1:0]         o_pc_jmpaddr
);

  issue_if issue ();
  csr_if   csr ();

  logic                     alu_fire;
  logic                     trap_start;
  logic                     trap_done;
  logic                     sel_trap;
  logic                     retire;
  logic [exe_pkg::xlen-1:0] alu_rd_wdata;
  logic                     alu_pc_jmp;
  logic [exe_pkg::xlen-1:0] alu_pc_jmpaddr;
  logic [exe_pkg::xlen-1:0] trap_pc_jmpaddr;
  logic                     trap_we;
  logic [exe_pkg::xlen-1:0] trap_epc;
  logic [exe_pkg::xlen-1:0] trap_cause;
  logic [exe_pkg::xlen-1:0] mtvec;
  logic [exe_pkg::xlen-1:0] mepc;
  logic [exe_pkg::xlen-1:0] instret;

  exe_ctrl u_exe_ctrl (
    .clk          (clk),
    .rst          (rst),
    .i_dec_req    (i_dec_req),
    .o_dec_ack    (o_dec_ack),
    .i_op         (i_op),
    .i_pc         (i_pc),
    .i_op1        (i_op1),
    .i_op2        (i_op2),
    .i_op3        (i_op3),
    .i_rd         (i_rd),
    .i_rd_wen     (i_rd_wen),
    .issue        (issue.src),
    .o_alu_fire   (alu_fire),
    .o_trap_start (trap_start),
    .i_trap_done  (trap_done),
    .o_sel_trap   (sel_trap),
    .o_exe_req    (o_exe_req),
    .i_exe_ack    (i_exe_ack),
    .o_retire     (retire)
  );

  alu_unit u_alu_unit (
    .clk          (clk),
    .rst          (rst),
    .issue        (issue.dst),
    .i_fire       (alu_fire),
    .csr          (csr.master),
    .o_rd_wdata   (alu_rd_wdata),
    .o_pc_jmp     (alu_pc_jmp),
    .o_pc_jmpaddr (alu_pc_jmpaddr)
  );

  trap_unit u_trap_unit (
    .clk          (clk),
    .rst          (rst),
    .issue        (issue.dst),
    .i_start      (trap_start),
    .i_mtvec      (mtvec),
    .i_mepc       (mepc),
    .o_trap_we    (trap_we),
    .o_trap_epc   (trap_epc),
    .o_trap_cause (trap_cause),
    .o_done       (trap_done),
    .o_pc_jmpaddr (trap_pc_jmpaddr)
  );

  csr_file u_csr_file (
    .clk          (clk),
    .rst          (rst),
    .csr          (csr.slave),
    .i_trap_we    (trap_we),
    .i_trap_epc   (trap_epc),
    .i_trap_cause (trap_cause),
    .i_instret    (instret),
    .o_mtvec      (mtvec),
    .o_mepc       (mepc)
  );

  instret_counter u_instret_counter (
    .clk      (clk),
    .rst      (rst),
    .i_retire (retire),
    .o_count  (instret)
  );

  assign o_pc         = issue.pc;
  assign o_rd         = issue.rd;
  assign o_rd_wen     = issue.rd_wen & ~sel_trap;
  assign o_rd_wdata   = sel_trap ? '0 : alu_rd_wdata;
  assign o_pc_jmp     = sel_trap | alu_pc_jmp;
  assign o_pc_jmpaddr = sel_trap ? trap_pc_jmpaddr : alu_pc_jmpaddr;

endmodule

`default_nettype wire

// ==== src/instret_counter.sv ====
// counts executed handshakes, wraps at 2^64
`default_nettype none

module instret_counter (
  input  wire                        clk,
  input  wire                        rst,
  input  wire                        i_retire,
  output logic [exe_pkg::xlen-1:0]   o_count
);

  always_ff @(posedge clk) begin
    if (rst) begin
      o_count <= '0;
    end else if (i_retire) begin
      o_count <= o_count + 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== src/trap_unit.sv ====
// step one writes mepc/mcause for ecall, step two latches the target
// mret only reads mepc, nothing is written
`default_nettype none

module trap_unit (
  input  wire                        clk,
  input  wire                        rst,
  issue_if.dst                       issue,
  input  wire                        i_start,
  input  wire  [exe_pkg::xlen-1:0]   i_mtvec,
  input  wire  [exe_pkg::xlen-1:0]   i_mepc,
  output logic                       o_trap_we,
  output logic [exe_pkg::xlen-1:0]   o_trap_epc,
  output logic [exe_pkg::xlen-1:0]   o_trap_cause,
  output logic                       o_done,
  output logic [exe_pkg::xlen-1:0]   o_pc_jmpaddr
);

  logic step;
  logic is_ecall;

  assign is_ecall = (issue.op == exe_pkg::OP_ECALL);

  // first step
  assign o_trap_we    = i_start & is_ecall;
  assign o_trap_epc   = issue.pc;
  assign o_trap_cause = exe_pkg::cause_ecall_m;

  // second step follows start by one cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      step <= 1'b0;
    end else begin
      step <= i_start;
    end
  end

  assign o_done = step;

  // mtvec is sampled after the epc write, harmless since it is untouched
  always_ff @(posedge clk) begin
    if (step) begin
      o_pc_jmpaddr <= is_ecall ? i_mtvec : i_mepc;
    end
  end

endmodule

`default_nettype wire

// ==== tb/tb_exe_stage.sv ====
// self-checking testbench for exe_stage_top with a reference model of the CSRs and retire count
// one instruction in flight; i_exe_ack back-pressure of 0 to 3 cycles
`default_nettype none

module tb_exe_stage;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int n_alu   = 40;
  localparam int n_csr   = 30;
  localparam int n_trap  = 5;
  localparam int n_bp    = 12;
  localparam int n_cnt   = 20;
  localparam int n_total = n_alu + n_csr + n_trap + n_bp + 2 * n_cnt;

  logic             clk;
  logic             rst;
  logic             i_dec_req;
  logic             o_dec_ack;
  exe_pkg::exe_op_t i_op;
  logic [63:0]      i_pc;
  logic [63:0]      i_op1;
  logic [63:0]      i_op2;
  logic [63:0]      i_op3;
  logic [4:0]       i_rd;
  logic             i_rd_wen;
  logic             o_exe_req;
  logic             i_exe_ack;
  logic [63:0]      o_pc;
  logic [4:0]       o_rd;
  logic             o_rd_wen;
  logic [63:0]      o_rd_wdata;
  logic             o_pc_jmp;
  logic [63:0]      o_pc_jmpaddr;

  // model state and expected results of the instruction in flight
  logic [63:0] m_mtvec;
  logic [63:0] m_mepc;
  logic [63:0] m_mcause;
  logic [63:0] m_mscratch;
  logic [63:0] m_count;
  logic [63:0] exp_wdata;
  logic [63:0] exp_addr;
  logic        exp_jmp;
  int          exp_lat;

  integer seed;
  int     errors;
  int     lat_errors;
  int     reset_errors;
  int     n_done;
  int     err_mark;
  int     done_mark;

  exe_stage_top u_exe_stage_top (.*);

  always #2 clk = ~clk;

  task automatic report_mismatch(input string name, input logic [63:0] expv,
                                 input logic [63:0] actv);
    $display("Mismatch at %0t ns: %s expected %h, got %h", $time, name, expv, actv);
    errors++;
  endtask

  task automatic report_failure(input string what);
    $display("Error at %0t ns: %s", $time, what);
    errors++;
  endtask

  function automatic logic [63:0] rand64();
    return {$random(seed), $random(seed)};
  endfunction

  function automatic exe_pkg::exe_op_t rand_op(input int unsigned span);
    int unsigned r;
    r = $unsigned($random(seed)) % span;
    return exe_pkg::exe_op_t'(r[3:0]);
  endfunction

  function automatic logic [11:0] rand_csr_addr();
    logic [31:0] r;
    r = $random(seed);
    case (r[18:16])
      3'd0: return 12'h305;
      3'd1: return 12'h341;
      3'd2: return 12'h342;
      3'd3: return 12'h340;
      3'd4: return 12'hB02;
      default: return r[11:0];
    endcase
  endfunction

  function automatic logic [63:0] model_csr_read(input logic [11:0] addr);
    case (addr)
      12'h305: return m_mtvec;
      12'h341: return m_mepc;
      12'h342: return m_mcause;
      12'h340: return m_mscratch;
      12'hB02: return m_count;
      default: return 64'd0;
    endcase
  endfunction

  // minstret and unknown addresses drop writes
  task automatic model_csr_write(input logic [11:0] addr, input logic [63:0] val);
    case (addr)
      12'h305: m_mtvec = val;
      12'h341: m_mepc = val;
      12'h342: m_mcause = val;
      12'h340: m_mscratch = val;
      default: ;
    endcase
  endtask

  task automatic model_exec(input exe_pkg::exe_op_t op, input logic [63:0] pc,
                            input logic [63:0] op1, input logic [63:0] op2,
                            input logic [63:0] op3);
    logic [63:0] old;
    old = model_csr_read(op3[11:0]);
    exp_wdata = 64'd0;
    exp_jmp = 1'b0;
    exp_addr = pc + op3;
    exp_lat = 2;
    case (op)
      exe_pkg::OP_ADD: exp_wdata = op1 + op2;
      exe_pkg::OP_SUB: exp_wdata = op1 - op2;
      exe_pkg::OP_AND: exp_wdata = op1 & op2;
      exe_pkg::OP_OR:  exp_wdata = op1 | op2;
      exe_pkg::OP_XOR: exp_wdata = op1 ^ op2;
      exe_pkg::OP_SLL: exp_wdata = op1 << op2[5:0];
      exe_pkg::OP_SRL: exp_wdata = op1 >> op2[5:0];
      exe_pkg::OP_SLT: exp_wdata = ($signed(op1) < $signed(op2)) ? 64'd1 : 64'd0;
      exe_pkg::OP_BEQ: exp_jmp = (op1 == op2);
      exe_pkg::OP_JAL: begin
        exp_wdata = pc + 64'd4;
        exp_jmp = 1'b1;
      end
      exe_pkg::OP_CSRRW: begin
        exp_wdata = old;
        model_csr_write(op3[11:0], op1);
      end
      exe_pkg::OP_CSRRS: begin
        exp_wdata = old;
        if (op1 != 64'd0) model_csr_write(op3[11:0], old | op1);
      end
      exe_pkg::OP_ECALL: begin
        m_mepc = pc;
        m_mcause = 64'd11;
        exp_jmp = 1'b1;
        exp_addr = m_mtvec;
        exp_lat = 3;
      end
      default: begin
        exp_jmp = 1'b1;
        exp_addr = m_mepc;
        exp_lat = 3;
      end
    endcase
  endtask

  task automatic run_instr(input exe_pkg::exe_op_t op, input logic [63:0] pc,
                           input logic [63:0] op1, input logic [63:0] op2,
                           input logic [63:0] op3, input int min_hold);
    logic [31:0] r;
    logic [4:0]  rd;
    logic        rd_wen;
    logic        is_trap;
    logic        exp_wen;
    logic [63:0] snap_wdata;
    logic [63:0] snap_addr;
    logic        snap_jmp;
    int          lat;
    int          hold;
    r = $random(seed);
    rd = r[4:0];
    rd_wen = r[5];
    hold = int'(r[9:8]);
    if (hold < min_hold) hold = min_hold;
    is_trap = (op == exe_pkg::OP_ECALL) || (op == exe_pkg::OP_MRET);
    exp_wen = rd_wen & ~is_trap;
    model_exec(op, pc, op1, op2, op3);
    @(posedge clk);
    i_dec_req <= 1'b1;
    i_op <= op;
    i_pc <= pc;
    i_op1 <= op1;
    i_op2 <= op2;
    i_op3 <= op3;
    i_rd <= rd;
    i_rd_wen <= rd_wen;
    @(negedge clk);
    while (o_dec_ack !== 1'b1) @(negedge clk);
    @(posedge clk);
    i_dec_req <= 1'b0;
    // edges counted after the accept edge
    lat = 0;
    @(negedge clk);
    while (o_exe_req !== 1'b1) begin
      @(negedge clk);
      lat++;
    end
    if (lat != exp_lat) begin
      report_mismatch("o_exe_req latency", 64'(exp_lat), 64'(lat));
      lat_errors++;
    end
    if (o_pc !== pc) report_mismatch("o_pc", pc, o_pc);
    if (o_rd !== rd) report_mismatch("o_rd", 64'(rd), 64'(o_rd));
    if (o_rd_wen !== exp_wen) report_mismatch("o_rd_wen", 64'(exp_wen), 64'(o_rd_wen));
    if (!is_trap && o_rd_wdata !== exp_wdata) begin
      report_mismatch("o_rd_wdata", exp_wdata, o_rd_wdata);
    end
    if (o_pc_jmp !== exp_jmp) report_mismatch("o_pc_jmp", 64'(exp_jmp), 64'(o_pc_jmp));
    if (exp_jmp && o_pc_jmpaddr !== exp_addr) begin
      report_mismatch("o_pc_jmpaddr", exp_addr, o_pc_jmpaddr);
    end
    snap_wdata = o_rd_wdata;
    snap_addr = o_pc_jmpaddr;
    snap_jmp = o_pc_jmp;
    repeat (hold) begin
      @(negedge clk);
      if (o_exe_req !== 1'b1 || o_dec_ack !== 1'b0) begin
        report_failure("handshake moved while i_exe_ack was low");
      end
      if (o_pc !== pc) report_mismatch("o_pc held", pc, o_pc);
      if (o_rd !== rd) report_mismatch("o_rd held", 64'(rd), 64'(o_rd));
      if (o_rd_wen !== exp_wen) report_mismatch("o_rd_wen held", 64'(exp_wen), 64'(o_rd_wen));
      if (o_rd_wdata !== snap_wdata) report_mismatch("o_rd_wdata held", snap_wdata, o_rd_wdata);
      if (o_pc_jmp !== snap_jmp) report_mismatch("o_pc_jmp held", 64'(snap_jmp), 64'(o_pc_jmp));
      if (o_pc_jmpaddr !== snap_addr) begin
        report_mismatch("o_pc_jmpaddr held", snap_addr, o_pc_jmpaddr);
      end
    end
    @(posedge clk);
    i_exe_ack <= 1'b1;
    @(posedge clk);
    i_exe_ack <= 1'b0;
    m_count++;
    n_done++;
    @(negedge clk);
    if (o_dec_ack !== 1'b1 || o_exe_req !== 1'b0) begin
      report_failure("o_dec_ack did not return after retire");
    end
  endtask

  task automatic start_test();
    err_mark = errors;
    done_mark = n_done;
  endtask

  task automatic end_test(input int num, input string name);
    $display("test %0d %s: %0d instructions, %0d errors", num, name,
             n_done - done_mark, errors - err_mark);
  endtask

  initial begin
    repeat (n_total * 10 + 100) @(posedge clk);
    $display("timeout: run did not finish within %0d cycles", n_total * 10 + 100);
    $display("test failed");
    $finish;
  end

  initial begin
    exe_pkg::exe_op_t op;
    logic [63:0]      a;
    logic [63:0]      b;
    logic [63:0]      pc_e;
    seed = 32'h15a8_cd99;
    errors = 0;
    lat_errors = 0;
    n_done = 0;
    clk = 1'b0;
    rst = 1'b1;
    i_dec_req = 1'b0;
    i_op = exe_pkg::OP_ADD;
    i_pc = 64'd0;
    i_op1 = 64'd0;
    i_op2 = 64'd0;
    i_op3 = 64'd0;
    i_rd = 5'd0;
    i_rd_wen = 1'b0;
    i_exe_ack = 1'b0;
    m_mtvec = 64'd0;
    m_mepc = 64'd0;
    m_mcause = 64'd0;
    m_mscratch = 64'd0;
    m_count = 64'd0;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    if (o_dec_ack !== 1'b1) report_failure("o_dec_ack low in the first cycle after reset");
    if (o_exe_req !== 1'b0 || o_pc_jmp !== 1'b0 || o_rd_wen !== 1'b0) begin
      report_failure("outputs not idle after reset");
    end
    reset_errors = errors;

    start_test();
    for (int i = 0; i < n_alu; i++) begin
      op = rand_op(10);
      a = rand64();
      // equal operands half the time so branches get taken
      b = (($random(seed) & 1) != 0) ? a : rand64();
      run_instr(op, rand64(), a, b, rand64(), 0);
    end
    end_test(1, "alu, branch and jump");

    start_test();
    for (int i = 0; i < n_csr; i++) begin
      op = (($random(seed) & 1) != 0) ? exe_pkg::OP_CSRRS : exe_pkg::OP_CSRRW;
      a = (($random(seed) & 1) != 0) ? 64'd0 : rand64();
      run_instr(op, rand64(), a, rand64(), (rand64() & ~64'hfff) | 64'(rand_csr_addr()), 0);
    end
    end_test(2, "csr read and write");

    start_test();
    pc_e = rand64();
    run_instr(exe_pkg::OP_CSRRW, rand64(), rand64() & ~64'h3, 64'd0, 64'h305, 0);
    run_instr(exe_pkg::OP_ECALL, pc_e, rand64(), rand64(), rand64(), 0);
    run_instr(exe_pkg::OP_CSRRS, rand64(), 64'd0, 64'd0, 64'h341, 0);
    run_instr(exe_pkg::OP_CSRRS, rand64(), 64'd0, 64'd0, 64'h342, 0);
    run_instr(exe_pkg::OP_MRET, rand64(), rand64(), rand64(), rand64(), 0);
    end_test(3, "ecall and mret");

    start_test();
    for (int i = 0; i < n_bp; i++) begin
      run_instr(rand_op(14), rand64(), rand64(), rand64(), 64'(rand_csr_addr()), 3);
    end
    end_test(4, "back-pressure");

    start_test();
    for (int i = 0; i < n_cnt; i++) begin
      run_instr(rand_op(10), rand64(), rand64(), rand64(), rand64(), 0);
      run_instr(exe_pkg::OP_CSRRS, rand64(), rand64(), rand64(), 64'hB02, 0);
    end
    end_test(5, "minstret");

    $display("test 6 latency and reset: %0d errors", reset_errors + lat_errors);
    $display("summary: %0d instructions retired, %0d errors", n_done, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
